//--- common/fas_pkg.sv
// Shared definitions for the filter and spectrum front end
//   Widths and counts of the FIR, frame collector and FFT
//   Sample, frame, complex and spectrum types
//   FIR coefficient table and FFT twiddle tables
//   Index bit reversal used for output reordering
`default_nettype none

package fas_pkg;

  localparam int SAMPLE_W   = 16;  // Input and FIR output width
  localparam int COEF_W     = 20;  // FIR coefficient width
  localparam int FIR_TAPS   = 32;
  localparam int FRAME_LEN  = 16;  // Points per FFT frame
  localparam int FFT_STAGES = 4;
  localparam int ACC_W      = 24;  // Internal FFT real and imaginary width
  localparam int TW_FRAC    = 16;  // Fraction bits of twiddles and coefficients
  localparam int TW_W       = TW_FRAC + 2;  // Holds +1.0 and -1.0 in Q16

  localparam int FIR_CNT_W   = $clog2(FIR_TAPS);
  localparam int FIR_SUM_W   = SAMPLE_W + COEF_W + FIR_CNT_W;  // Full precision MAC
  localparam int FRAME_IDX_W = $clog2(FRAME_LEN);

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEF_W-1:0]   coef_t;

  typedef struct packed {
    sample_t [FRAME_LEN-1:0] s;  // Index 0 is the oldest sample
  } frame_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] re;
    logic signed [ACC_W-1:0] im;
  } cplx_t;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;
  } bin_t;

  typedef struct packed {
    bin_t [FRAME_LEN-1:0] bin;  // Natural bin order
  } spectrum_t;

  // Low-pass taps, entry 0 weights the newest sample
  localparam coef_t FIR_COEF [FIR_TAPS] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E
  };

  // W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
  localparam logic signed [TW_W-1:0] TW_RE [FRAME_LEN/2] = '{
    65536, 60547, 46340, 25079, 0, -25079, -46340, -60547
  };
  localparam logic signed [TW_W-1:0] TW_IM [FRAME_LEN/2] = '{
    0, -25079, -46340, -60547, -65536, -60547, -46340, -25079
  };

  // Reverses the FFT_STAGES low bits of an index
  function automatic int unsigned bit_rev(input int unsigned idx);
    int unsigned rev;
    rev = 0;
    for (int b = 0; b < FFT_STAGES; b++) begin
      rev = (rev << 1) | ((idx >> b) & 1);
    end
    return rev;
  endfunction

endpackage

`default_nettype wire

//--- fir/fir_filter.sv
// 32-tap symmetric low-pass FIR filter
//   Sample history shifted on each accepted sample
//   Saturating warm-up counter that qualifies the output
//   Full precision multiply-accumulate and output rounding
`timescale 1ns/10ps
`default_nettype none

module fir_filter (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_valid,
  input  fas_pkg::sample_t  data,
  output logic              fir_valid,
  output fas_pkg::sample_t  fir_d
);

  fas_pkg::sample_t [fas_pkg::FIR_TAPS-2:0] hist;  // Past samples, index 0 newest
  fas_pkg::sample_t [fas_pkg::FIR_TAPS-1:0] win;   // Window including the incoming sample
  logic [fas_pkg::FIR_CNT_W-1:0]            warm_cnt;
  logic                                     warm_done;

  logic signed [fas_pkg::FIR_SUM_W-1:0] acc;
  logic signed [fas_pkg::FIR_SUM_W-1:0] shifted;
  fas_pkg::sample_t                     rounded;

  assign win       = {hist, data};  // Incoming sample lands at index 0
  assign warm_done = (warm_cnt == fas_pkg::FIR_CNT_W'(fas_pkg::FIR_TAPS - 1));

  //////////////////////////////////////////////////////////////////////
  // Multiply-accumulate and rounding
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    acc = '0;
    for (int i = 0; i < fas_pkg::FIR_TAPS; i++) begin
      acc = acc + win[i] * fas_pkg::FIR_COEF[i];
    end
  end

  always_comb begin
    shifted = acc >>> fas_pkg::TW_FRAC;  // Drop the Q16 fraction
    // Negative sums are bumped by one before truncation
    rounded = shifted[fas_pkg::SAMPLE_W-1:0]
            + fas_pkg::SAMPLE_W'(acc[fas_pkg::FIR_SUM_W-1]);
  end

  //////////////////////////////////////////////////////////////////////
  // History, warm-up and output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist      <= '0;
      warm_cnt  <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else if (data_valid) begin
      hist      <= win[fas_pkg::FIR_TAPS-2:0];  // Shift by one sample
      fir_d     <= rounded;
      fir_valid <= warm_done;  // High from the 32nd consecutive sample
      if (!warm_done) begin
        warm_cnt <= warm_cnt + 1'b1;
      end
    end else begin
      warm_cnt  <= '0;  // A gap restarts the warm-up
      fir_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/frame_collector.sv
// Serial to parallel frame collector
//   Write index over valid FIR outputs
//   Frame register and one-cycle frame pulse
`timescale 1ns/10ps
`default_nettype none

module frame_collector (
  input  logic              clk,
  input  logic              rst,
  input  logic              fir_valid,
  input  fas_pkg::sample_t  fir_d,
  output logic              frame_valid,
  output fas_pkg::frame_t   frame
);

  logic [fas_pkg::FRAME_IDX_W-1:0] wr_idx;  // Next slot to fill
  logic                            last_slot;

  assign last_slot = (wr_idx == fas_pkg::FRAME_IDX_W'(fas_pkg::FRAME_LEN - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_idx      <= '0;
      frame_valid <= 1'b0;
      frame       <= '0;
    end else begin
      frame_valid <= 1'b0;
      if (fir_valid) begin
        frame.s[wr_idx] <= fir_d;
        if (last_slot) begin
          frame_valid <= 1'b1;  // Frame complete
          wr_idx      <= '0;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end else begin
        // Partial frame is dropped when the stream breaks
        wr_idx <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- fft/fft_stage.sv
// One radix-2 DIF butterfly stage over a 16-point frame
//   Pairs at span 8 >> STAGE, sum on the upper output
//   Difference times twiddle on the lower output, Q16 rescaled
//   Registered data and valid
`timescale 1ns/10ps
`default_nettype none

module fft_stage #(
  parameter int STAGE = 0
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    in_valid,
  input  fas_pkg::cplx_t [fas_pkg::FRAME_LEN-1:0] in_data,
  output logic                                    out_valid,
  output fas_pkg::cplx_t [fas_pkg::FRAME_LEN-1:0] out_data
);

  localparam int SPAN = (fas_pkg::FRAME_LEN / 2) >> STAGE;  // Butterfly distance

  fas_pkg::cplx_t [fas_pkg::FRAME_LEN-1:0] nxt;

  //////////////////////////////////////////////////////////////////////
  // Butterflies
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    logic signed [fas_pkg::ACC_W:0]              d_re;
    logic signed [fas_pkg::ACC_W:0]              d_im;
    logic signed [fas_pkg::ACC_W+fas_pkg::TW_W:0] p_re;
    logic signed [fas_pkg::ACC_W+fas_pkg::TW_W:0] p_im;
    int                                          hi;
    int                                          tw;
    nxt  = '0;
    d_re = '0;
    d_im = '0;
    p_re = '0;
    p_im = '0;
    hi   = 0;
    tw   = 0;
    for (int g = 0; g < fas_pkg::FRAME_LEN; g += 2 * SPAN) begin
      for (int k = 0; k < SPAN; k++) begin
        hi = g + k + SPAN;
        tw = k << STAGE;  // Twiddle step grows with the stage
        nxt[g+k].re = in_data[g+k].re + in_data[hi].re;
        nxt[g+k].im = in_data[g+k].im + in_data[hi].im;
        d_re = in_data[g+k].re - in_data[hi].re;
        d_im = in_data[g+k].im - in_data[hi].im;
        // Complex multiply by W16^tw
        p_re = d_re * fas_pkg::TW_RE[tw] - d_im * fas_pkg::TW_IM[tw];
        p_im = d_re * fas_pkg::TW_IM[tw] + d_im * fas_pkg::TW_RE[tw];
        nxt[hi].re = p_re[fas_pkg::TW_FRAC +: fas_pkg::ACC_W];  // Arithmetic shift by 16
        nxt[hi].im = p_im[fas_pkg::TW_FRAC +: fas_pkg::ACC_W];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= in_valid;
      out_data  <= nxt;
    end
  end

endmodule

`default_nettype wire

//--- fft/fft16.sv
// 16-point radix-2 decimation-in-frequency FFT
//   Real to complex extension of the incoming frame
//   Four registered butterfly stages with their valid bits
//   Bit-reversed to natural order mapping and bin packing
`timescale 1ns/10ps
`default_nettype none

module fft16 (
  input  logic                clk,
  input  logic                rst,
  input  logic                frame_valid,
  input  fas_pkg::frame_t     frame,
  output logic                fft_valid,
  output fas_pkg::spectrum_t  spectrum
);

  fas_pkg::cplx_t [fas_pkg::FRAME_LEN-1:0] stage_data [fas_pkg::FFT_STAGES+1];
  logic [fas_pkg::FFT_STAGES:0]            stage_valid;

  // Sign bit followed by the low 15 bits of the internal value
  function automatic logic signed [fas_pkg::SAMPLE_W-1:0] to_field(
    input logic signed [fas_pkg::ACC_W-1:0] v
  );
    return {v[fas_pkg::ACC_W-1], v[fas_pkg::SAMPLE_W-2:0]};
  endfunction

  always_comb begin
    for (int i = 0; i < fas_pkg::FRAME_LEN; i++) begin
      stage_data[0][i].re = frame.s[i];  // Sign extended
      stage_data[0][i].im = '0;
    end
  end

  assign stage_valid[0] = frame_valid;

  for (genvar s = 0; s < fas_pkg::FFT_STAGES; s++) begin : g_stage
    fft_stage #(.STAGE(s)) u_fft_stage (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (stage_valid[s]),
      .in_data   (stage_data[s]),
      .out_valid (stage_valid[s+1]),
      .out_data  (stage_data[s+1])
    );
  end

  // DIF leaves bin k at the bit-reversed position of k
  always_comb begin
    for (int k = 0; k < fas_pkg::FRAME_LEN; k++) begin
      spectrum.bin[k].re = to_field(stage_data[fas_pkg::FFT_STAGES][fas_pkg::bit_rev(k)].re);
      spectrum.bin[k].im = to_field(stage_data[fas_pkg::FFT_STAGES][fas_pkg::bit_rev(k)].im);
    end
  end

  assign fft_valid = stage_valid[fas_pkg::FFT_STAGES];

endmodule

`default_nettype wire

//--- design/fas_top.sv
// Top level of the filter and spectrum front end
//   FIR filter, frame collector and 16-point FFT in a chain
`timescale 1ns/10ps
`default_nettype none

module fas_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                data_valid,
  input  fas_pkg::sample_t    data,
  output logic                fir_valid,
  output fas_pkg::sample_t    fir_d,
  output logic                fft_valid,
  output fas_pkg::spectrum_t  spectrum
);

  logic             frame_valid;  // One-cycle pulse per full frame
  fas_pkg::frame_t  frame;

  fir_filter u_fir_filter (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_collector u_frame_collector (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  fft16 u_fft16 (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .fft_valid   (fft_valid),
    .spectrum    (spectrum)
  );

endmodule

`default_nettype wire

//--- sim/fas_sva.sv
// Concurrent assertions on the valid outputs of the front end
//   Single-cycle fft_valid pulses with a minimum spacing of one frame
//   fir_valid only after an accepted input sample
//   Bound into the top level
`timescale 1ns/10ps
`default_nettype none

module fas_sva (
  input logic clk,
  input logic rst,
  input logic data_valid,
  input logic fir_valid,
  input logic fft_valid
);

  logic [5:0] since_fft;  // Cycles since the last fft_valid, saturating

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      since_fft <= '1;
    end else if (fft_valid) begin
      since_fft <= 6'd1;
    end else if (since_fft != '1) begin
      since_fft <= since_fft + 1'b1;
    end
  end

  a_fft_pulse: assert property (@(posedge clk) disable iff (rst)
    fft_valid |=> !fft_valid)
    else $error("fft_valid high on two consecutive cycles");

  a_fft_spacing: assert property (@(posedge clk) disable iff (rst)
    fft_valid |-> since_fft >= 6'd16)
    else $error("fft_valid pulses closer than one frame apart");

  a_fir_after_input: assert property (@(posedge clk) disable iff (rst)
    fir_valid |-> $past(data_valid))
    else $error("fir_valid high without an accepted sample");

endmodule

bind fas_top fas_sva u_fas_sva (
  .clk        (clk),
  .rst        (rst),
  .data_valid (data_valid),
  .fir_valid  (fir_valid),
  .fft_valid  (fft_valid)
);

`default_nettype wire

//--- sim/tb_fas.sv
// Testbench for the filter and spectrum front end
//   Clock, reset and table-driven stimulus
//   FIR reference model with its own sample history
//   Frame tracking with checks of fft_valid timing and spectrum bins
`timescale 1ns/10ps
`default_nettype none

module tb_fas;

  localparam logic [1:0] K_CONST   = 2'd0;
  localparam logic [1:0] K_IMPULSE = 2'd1;
  localparam logic [1:0] K_RANDOM  = 2'd2;
  localparam logic [1:0] K_GAP     = 2'd3;

  localparam int NUM_ROWS      = 10;
  localparam int FFT_LAT       = 5;   // fir_valid seen to fft_valid seen
  localparam int DRAIN_TIMEOUT = 40;

  typedef struct packed {
    logic [1:0] kind;
    int         value;
    int         count;
  } stim_row_t;

  typedef struct packed {
    int   due;   // Monitor cycle in which fft_valid is due
    int   sum;   // Sum of the 16 frame samples
    logic flat;  // All frame samples equal
  } frame_exp_t;

  logic               clk;
  logic               rst;
  logic               data_valid;
  fas_pkg::sample_t   data;
  logic               fir_valid;
  fas_pkg::sample_t   fir_d;
  logic               fft_valid;
  fas_pkg::spectrum_t spectrum;

  // Rows of kind, value and sample count
  stim_row_t stim_tab [NUM_ROWS] = '{
    '{K_GAP,         0,   2},
    '{K_CONST,       0,  32},
    '{K_IMPULSE, 16384,  32},  // Impulse followed by 31 zeros
    '{K_GAP,         0,   1},
    '{K_CONST,    1000,  80},
    '{K_GAP,         0,   1},
    '{K_CONST,   -3000,  64},
    '{K_RANDOM,      0, 160},
    '{K_GAP,         0,   1},  // Single-cycle break in the stream
    '{K_RANDOM,      0, 100}
  };

  integer           seed = 56805;
  logic             mon_en;
  int               cyc;
  int               m_hist [fas_pkg::FIR_TAPS];  // Model history with the newest at index 0
  int               m_warm;
  logic             exp_fir_valid;
  fas_pkg::sample_t exp_fir_d;
  int               fr_buf [fas_pkg::FRAME_LEN];
  int               fr_cnt;
  frame_exp_t       exp_q [$];

  fas_top u_fas_top (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .fft_valid  (fft_valid),
    .spectrum   (spectrum)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and reference helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input longint actual, input longint expected, input string what);
    if (actual != expected) begin
      $display("[ERROR] %0t ns: %s: got %0d, expected %0d", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // Shift out the Q16 fraction and bump negative sums by one
  function automatic fas_pkg::sample_t fir_round(input longint acc);
    longint sh;
    sh = acc >>> fas_pkg::TW_FRAC;
    if (acc < 0) begin
      sh = sh + 1;
    end
    return fas_pkg::sample_t'(sh);
  endfunction

  function automatic fas_pkg::sample_t expected_field(input int v);
    return {v[31], v[14:0]};  // Sign bit followed by the low 15 bits
  endfunction

  task automatic check_spectrum(input frame_exp_t e);
    check_value(spectrum.bin[0].re, expected_field(e.sum), "bin 0 re against frame sum");
    check_value(spectrum.bin[0].im, 0, "bin 0 im");
    if (e.flat) begin
      for (int k = 1; k < fas_pkg::FRAME_LEN; k++) begin
        check_value(spectrum.bin[k].re, 0, $sformatf("bin %0d re of constant frame", k));
        check_value(spectrum.bin[k].im, 0, $sformatf("bin %0d im of constant frame", k));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor and model sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    longint     acc;
    int         s;
    logic       flat;
    logic       exp_pulse;
    frame_exp_t e;
    if (mon_en) begin
      cyc = cyc + 1;
      check_value(fir_valid, exp_fir_valid, "fir_valid against model");
      if (exp_fir_valid) begin
        check_value(fir_d, exp_fir_d, "fir_d against model");
        fr_buf[fr_cnt] = exp_fir_d;
        fr_cnt = fr_cnt + 1;
        if (fr_cnt == fas_pkg::FRAME_LEN) begin
          s = 0;
          flat = 1'b1;
          for (int i = 0; i < fas_pkg::FRAME_LEN; i++) begin
            s = s + fr_buf[i];
            if (fr_buf[i] != fr_buf[0]) flat = 1'b0;
          end
          e.due  = cyc + FFT_LAT;
          e.sum  = s;
          e.flat = flat;
          exp_q.push_back(e);
          fr_cnt = 0;
        end
      end else begin
        fr_cnt = 0;  // Partial frame discarded
      end

      exp_pulse = (exp_q.size() != 0) && (exp_q[0].due == cyc);
      check_value(fft_valid, exp_pulse, "fft_valid timing");
      if (exp_pulse) begin
        e = exp_q.pop_front();
        check_spectrum(e);
      end

      // Inputs seen here are taken at the next rising edge
      if (data_valid) begin
        for (int i = fas_pkg::FIR_TAPS - 1; i > 0; i--) begin
          m_hist[i] = m_hist[i-1];
        end
        m_hist[0] = data;
        acc = 0;
        for (int i = 0; i < fas_pkg::FIR_TAPS; i++) begin
          acc = acc + longint'(m_hist[i]) * longint'(fas_pkg::FIR_COEF[i]);
        end
        if (m_warm < fas_pkg::FIR_TAPS) m_warm = m_warm + 1;
        exp_fir_valid = (m_warm == fas_pkg::FIR_TAPS);
        exp_fir_d     = fir_round(acc);
      end else begin
        m_warm        = 0;
        exp_fir_valid = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int timeout;
    rst            = 1'b1;
    data_valid     = 1'b0;
    data           = '0;
    mon_en         = 1'b0;
    cyc            = 0;
    m_warm         = 0;
    exp_fir_valid  = 1'b0;
    exp_fir_d      = '0;
    fr_cnt         = 0;
    for (int i = 0; i < fas_pkg::FIR_TAPS; i++) m_hist[i] = 0;

    for (int c = 0; c < 3; c++) begin
      @(posedge clk);
      #1;
      check_value(fir_valid, 0, "fir_valid during reset");
      check_value(fft_valid, 0, "fft_valid during reset");
    end
    rst    = 1'b0;
    mon_en = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int n = 0; n < stim_tab[r].count; n++) begin
        case (stim_tab[r].kind)
          K_CONST: begin
            data_valid = 1'b1;
            data       = fas_pkg::sample_t'(stim_tab[r].value);
          end
          K_IMPULSE: begin
            data_valid = 1'b1;
            data       = (n == 0) ? fas_pkg::sample_t'(stim_tab[r].value) : '0;
          end
          K_RANDOM: begin
            data_valid = 1'b1;
            data       = fas_pkg::sample_t'($random(seed) % 1024);  // Magnitude below 1024
          end
          default: begin
            data_valid = 1'b0;
            data       = '0;
          end
        endcase
        @(posedge clk);
        #1;
      end
    end
    data_valid = 1'b0;
    data       = '0;

    timeout = 0;
    while ((exp_q.size() != 0) && (timeout < DRAIN_TIMEOUT)) begin
      @(posedge clk);
      timeout = timeout + 1;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: expected spectrum frames never arrived on fft_valid");
      abort_run();
    end else begin
      repeat (4) @(posedge clk);  // Quiet cycles with no further fft_valid
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- files.f
common/fas_pkg.sv
fir/fir_filter.sv
design/frame_collector.sv
fft/fft_stage.sv
fft/fft16.sv
design/fas_top.sv
sim/fas_sva.sv
sim/tb_fas.sv

//--- Bender.yml
package:
  name: fas

sources:
  - common/fas_pkg.sv
  - fir/fir_filter.sv
  - design/frame_collector.sv
  - fft/fft_stage.sv
  - fft/fft16.sv
  - design/fas_top.sv
  - target: simulation
    files:
      - sim/fas_sva.sv
      - sim/tb_fas.sv
